//--- files.f
rtl/loader_pkg.sv
rtl/imem_port_if.sv
rtl/baud_tick_gen.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/instr_loader.sv
rtl/instr_mem.sv
rtl/fetch_unit.sv
rtl/reg_file.sv
rtl/mem_system_top.sv
test/tb_mem_system.sv

//--- run.sh
#!/usr/bin/env bash
# build the testbench and RTL with verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_mem_system -f files.f || exit 1
out="$(./obj_dir/Vtb_mem_system)"
echo "$out"
echo "$out" | grep -qx "STATUS: PASS" && exit 0 || exit 1

//--- test/tb_mem_system.sv
`timescale 1ns/1ps

module tb_mem_system;
    import loader_pkg::*;

    // bit and frame lengths in clocks
    localparam int BIT_CLKS    = TICKS_PER_BIT * CLKS_PER_TICK;
    localparam int FRAME_CLKS  = 11 * BIT_CLKS;
    // 16 frames of 10 bits, plus room for reset and fetches
    localparam int CYCLE_LIMIT = 16 * 10 * BIT_CLKS + 2000;

    logic                  clock;
    logic                  rst_i;
    logic [BYTE_W-1:0]     tx_data_i;
    logic                  tx_start_i;
    logic                  fetch_en_i;
    logic                  jump_i;
    logic [ADDR_W-1:0]     next_addr_i;
    logic                  reg_wr_en_i;
    logic [REG_ADDR_W-1:0] reg_wr_addr_i;
    logic [WORD_W-1:0]     reg_wr_data_i;
    logic                  tx_serial_o;
    logic                  tx_busy_o;
    logic                  tx_done_o;
    logic [BYTE_W-1:0]     rx_data_o;
    logic                  rx_done_o;
    logic [COUNT_W-1:0]    load_count_o;
    logic [ADDR_W-1:0]     pc_o;
    logic [WORD_W-1:0]     instruction_o;
    logic                  instr_valid_o;
    logic [WORD_W-1:0]     data_ra_o;
    logic [WORD_W-1:0]     data_rb_o;

    // reference models
    logic [WORD_W-1:0] model_mem [IMEM_DEPTH];
    logic [WORD_W-1:0] model_regs [2**REG_ADDR_W];
    logic [ADDR_W-1:0] model_pc;

    int                errors;
    int                checks;
    int                cycle_cnt;
    int                rx_count;
    logic [BYTE_W-1:0] rx_last;

    mem_system_top mem_system_top_inst (.*);

    always #50 clock = ~clock;

    // receiver pulses, counted mid-cycle
    always @(negedge clock) begin
        if (rx_done_o) begin
            rx_count++;
            rx_last = rx_data_o;
        end
    end

    // hard stop for a hung run
    always @(posedge clock) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", cycle_cnt);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic check_flag(input logic act, input logic exp, input string what);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %0t ns: %s is %b, expected %b", $time, what, act, exp);
        end
    endtask

    task automatic check_byte(input logic [BYTE_W-1:0] act, input logic [BYTE_W-1:0] exp,
                              input string what);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %0t ns: %s is %h, expected %h", $time, what, act, exp);
        end
    endtask

    task automatic check_word(input logic [WORD_W-1:0] act, input logic [WORD_W-1:0] exp,
                              input string what);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %0t ns: %s is %h, expected %h", $time, what, act, exp);
        end
    endtask

    task automatic check_addr(input logic [ADDR_W-1:0] act, input logic [ADDR_W-1:0] exp,
                              input string what);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %0t ns: %s is %0d, expected %0d", $time, what, act, exp);
        end
    endtask

    task automatic check_count(input logic [COUNT_W-1:0] act, input logic [COUNT_W-1:0] exp,
                               input string what);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %0t ns: %s is %0d, expected %0d", $time, what, act, exp);
        end
    endtask

    // register zero reads as zero
    function automatic logic [WORD_W-1:0] model_reg_read(input logic [REG_ADDR_W-1:0] idx);
        return (idx == '0) ? '0 : model_regs[idx];
    endfunction

    // hold reset for 16 clocks, model pc follows
    task automatic apply_reset();
        rst_i    = 1'b1;
        model_pc = '0;
        repeat (16) @(posedge clock);
        #1;
        rst_i = 1'b0;
    endtask

    task automatic check_reset_state();
        check_flag(tx_serial_o, 1'b1, "tx_serial_o after reset");
        check_flag(tx_busy_o, 1'b0, "tx_busy_o after reset");
        check_flag(tx_done_o, 1'b0, "tx_done_o after reset");
        check_flag(rx_done_o, 1'b0, "rx_done_o after reset");
        check_flag(instr_valid_o, 1'b0, "instr_valid_o after reset");
        check_count(load_count_o, '0, "load_count_o after reset");
        check_addr(pc_o, '0, "pc_o after reset");
        check_word(instruction_o, '0, "instruction_o after reset");
        check_word(data_ra_o, '0, "data_ra_o after reset");
        check_word(data_rb_o, '0, "data_rb_o after reset");
    endtask

    // poke adds a second strobe in the middle of the frame
    task automatic send_byte(input logic [BYTE_W-1:0] b, input logic poke);
        int n;
        int rx_before;
        logic seen;
        n = 0;
        seen = 1'b0;
        rx_before = rx_count;
        @(posedge clock);
        #1;
        tx_data_i  = b;
        tx_start_i = 1'b1;
        while (!seen && n < FRAME_CLKS) begin
            @(posedge clock);
            #1;
            tx_start_i = poke && (n == 500);
            if (poke && n == 500) begin
                tx_data_i = ~b;
                check_flag(tx_busy_o, 1'b1, "tx_busy_o at extra strobe");
            end
            seen = tx_done_o;
            n++;
        end
        if (!seen) begin
            errors++;
            $display("no tx_done_o within %0d cycles for byte %h", FRAME_CLKS, b);
        end else if (rx_count != rx_before + 1) begin
            errors++;
            $display("rx_done_o did not pulse once before tx_done_o for byte %h", b);
        end else begin
            check_byte(rx_last, b, "rx_data_o");
        end
    endtask

    task automatic loopback_test();
        int rx_before;
        logic line_moved;
        send_byte(8'($urandom), 1'b0);
        send_byte(8'($urandom), 1'b0);
        rx_before = rx_count;
        send_byte(8'($urandom), 1'b1);
        // an accepted extra strobe would pull the line low again
        line_moved = 1'b0;
        repeat (2 * BIT_CLKS) begin
            @(posedge clock);
            #1;
            if (tx_busy_o || !tx_serial_o) begin
                line_moved = 1'b1;
            end
        end
        if (line_moved || rx_count != rx_before + 1) begin
            errors++;
            $display("start strobe given while busy was not ignored");
        end
    endtask

    // first byte lands in the low bits of the word
    task automatic load_word(input int idx, input logic [REG_ADDR_W-1:0] rs,
                             input logic [REG_ADDR_W-1:0] rt);
        logic [WORD_W-1:0] w;
        w = $urandom;
        w[25:21] = rs;
        w[20:16] = rt;
        for (int i = 0; i < BYTES_PER_WORD; i++) begin
            send_byte(w[BYTE_W*i +: BYTE_W], 1'b0);
        end
        model_mem[idx % IMEM_DEPTH] = w;
        check_count(load_count_o, COUNT_W'(idx + 1), "load_count_o");
    endtask

    task automatic fetch(input logic do_jump, input logic [ADDR_W-1:0] target);
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] exp_word;
        addr = do_jump ? target : model_pc;
        exp_word = model_mem[addr];
        model_pc = addr + 1'b1;
        @(posedge clock);
        #1;
        fetch_en_i  = 1'b1;
        jump_i      = do_jump;
        next_addr_i = target;
        @(posedge clock);
        #1;
        fetch_en_i = 1'b0;
        jump_i     = 1'b0;
        check_flag(instr_valid_o, 1'b1, "instr_valid_o after fetch");
        check_word(instruction_o, exp_word, "instruction_o");
        check_addr(pc_o, addr, "pc_o");
        check_word(data_ra_o, model_reg_read(exp_word[25:21]), "data_ra_o");
        check_word(data_rb_o, model_reg_read(exp_word[20:16]), "data_rb_o");
        @(posedge clock);
        #1;
        check_flag(instr_valid_o, 1'b0, "instr_valid_o one cycle later");
    endtask

    task automatic write_reg(input logic [REG_ADDR_W-1:0] a, input logic [WORD_W-1:0] d);
        @(posedge clock);
        #1;
        reg_wr_en_i   = 1'b1;
        reg_wr_addr_i = a;
        reg_wr_data_i = d;
        @(posedge clock);
        #1;
        reg_wr_en_i = 1'b0;
        if (a != '0) begin
            model_regs[a] = d;
        end
    endtask

    initial begin
        clock         = 1'b0;
        rst_i         = 1'b1;
        tx_data_i     = '0;
        tx_start_i    = 1'b0;
        fetch_en_i    = 1'b0;
        jump_i        = 1'b0;
        next_addr_i   = '0;
        reg_wr_en_i   = 1'b0;
        reg_wr_addr_i = '0;
        reg_wr_data_i = '0;
        errors        = 0;
        checks        = 0;
        cycle_cnt     = 0;
        rx_count      = 0;
        model_pc      = '0;
        void'($urandom(32'h475beb38));
        for (int i = 0; i < 2**REG_ADDR_W; i++) begin
            model_regs[i] = '0;
        end
        apply_reset();

        check_reset_state();
        loopback_test();
        // loader byte groups start fresh, loopback bytes are not program
        apply_reset();
        // rs and rt picked so that index zero shows up
        load_word(0, 5'd0, 5'd3);
        load_word(1, 5'd5, 5'd0);
        load_word(2, 5'd3, 5'd7);
        // in order from reset
        fetch(1'b0, '0);
        fetch(1'b0, '0);
        fetch(1'b0, '0);
        // jump back, then carry on in order
        fetch(1'b1, 7'd1);
        fetch(1'b0, '0);
        // operands, write to zero must be dropped
        write_reg(5'd0, $urandom);
        write_reg(5'd3, $urandom);
        write_reg(5'd5, $urandom);
        write_reg(5'd7, $urandom);
        fetch(1'b1, 7'd0);
        fetch(1'b0, '0);
        fetch(1'b0, '0);

        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- rtl/mem_system_top.sv
`timescale 1ns/1ps

module mem_system_top (
    input  logic                              clock,
    input  logic                              rst_i,
    input  logic [loader_pkg::BYTE_W-1:0]     tx_data_i,
    input  logic                              tx_start_i,
    input  logic                              fetch_en_i,
    input  logic                              jump_i,
    input  logic [loader_pkg::ADDR_W-1:0]     next_addr_i,
    input  logic                              reg_wr_en_i,
    input  logic [loader_pkg::REG_ADDR_W-1:0] reg_wr_addr_i,
    input  logic [loader_pkg::WORD_W-1:0]     reg_wr_data_i,
    output logic                              tx_serial_o,
    output logic                              tx_busy_o,
    output logic                              tx_done_o,
    output logic [loader_pkg::BYTE_W-1:0]     rx_data_o,
    output logic                              rx_done_o,
    output logic [loader_pkg::COUNT_W-1:0]    load_count_o,
    output logic [loader_pkg::ADDR_W-1:0]     pc_o,
    output logic [loader_pkg::WORD_W-1:0]     instruction_o,
    output logic                              instr_valid_o,
    output logic [loader_pkg::WORD_W-1:0]     data_ra_o,
    output logic [loader_pkg::WORD_W-1:0]     data_rb_o
);

    // shared oversampling tick, one phase for both uarts
    logic tick;

    imem_port_if imem_port ();

    baud_tick_gen baud_tick_gen_inst (.clock(clock), .rst_i(rst_i), .tick_o(tick));

    uart_tx uart_tx_inst (
        .clock(clock), .rst_i(rst_i), .tick_i(tick),
        .tx_start_i(tx_start_i), .tx_data_i(tx_data_i),
        .tx_serial_o(tx_serial_o), .tx_busy_o(tx_busy_o), .tx_done_o(tx_done_o)
    );

    // loopback, tx line straight into rx
    uart_rx uart_rx_inst (
        .clock(clock), .rst_i(rst_i), .tick_i(tick), .rx_serial_i(tx_serial_o),
        .rx_data_o(rx_data_o), .rx_done_o(rx_done_o)
    );

    instr_loader instr_loader_inst (
        .clock(clock), .rst_i(rst_i), .byte_i(rx_data_o), .byte_done_i(rx_done_o),
        .mem(imem_port.loader), .load_count_o(load_count_o)
    );

    instr_mem instr_mem_inst (.clock(clock), .mem(imem_port.memory));

    fetch_unit fetch_unit_inst (
        .clock(clock), .rst_i(rst_i), .fetch_en_i(fetch_en_i), .jump_i(jump_i),
        .next_addr_i(next_addr_i), .mem(imem_port.fetch), .pc_o(pc_o),
        .instruction_o(instruction_o), .instr_valid_o(instr_valid_o)
    );

    // operands from the rs and rt fields of the fetched word
    reg_file reg_file_inst (
        .clock(clock), .rst_i(rst_i), .wr_en_i(reg_wr_en_i), .wr_addr_i(reg_wr_addr_i),
        .wr_data_i(reg_wr_data_i), .instr_i(instruction_o),
        .data_ra_o(data_ra_o), .data_rb_o(data_rb_o)
    );

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                              clock,
    input  logic                              rst_i,
    input  logic                              wr_en_i,
    input  logic [loader_pkg::REG_ADDR_W-1:0] wr_addr_i,
    input  logic [loader_pkg::WORD_W-1:0]     wr_data_i,
    input  logic [loader_pkg::WORD_W-1:0]     instr_i,
    output logic [loader_pkg::WORD_W-1:0]     data_ra_o,
    output logic [loader_pkg::WORD_W-1:0]     data_rb_o
);
    import loader_pkg::*;

    logic [WORD_W-1:0]     regs [2**REG_ADDR_W];
    logic [REG_ADDR_W-1:0] ra;
    logic [REG_ADDR_W-1:0] rb;

    // rs and rt fields of the instruction
    assign ra = instr_i[25:21];
    assign rb = instr_i[20:16];

    always_ff @(posedge clock) begin
        if (rst_i) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            // index zero is never written
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // combinational reads, $zero forced
    assign data_ra_o = (ra == '0) ? '0 : regs[ra];
    assign data_rb_o = (rb == '0) ? '0 : regs[rb];

endmodule

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                          clock,
    input  logic                          rst_i,
    input  logic                          fetch_en_i,
    input  logic                          jump_i,
    input  logic [loader_pkg::ADDR_W-1:0] next_addr_i,
    imem_port_if.fetch                    mem,
    output logic [loader_pkg::ADDR_W-1:0] pc_o,
    output logic [loader_pkg::WORD_W-1:0] instruction_o,
    output logic                          instr_valid_o
);
    import loader_pkg::*;

    logic [ADDR_W-1:0] pc_q;
    logic [ADDR_W-1:0] fetch_addr;
    logic              fetched_q;

    // jump overrides the sequential pc
    assign fetch_addr  = jump_i ? next_addr_i : pc_q;
    assign mem.rd_en   = fetch_en_i;
    assign mem.rd_addr = fetch_addr;

    always_ff @(posedge clock) begin
        if (rst_i) begin
            pc_q          <= '0;
            pc_o          <= '0;
            instr_valid_o <= 1'b0;
            fetched_q     <= 1'b0;
        end else begin
            // valid lines up with the registered memory read
            instr_valid_o <= fetch_en_i;
            if (fetch_en_i) begin
                pc_o      <= fetch_addr;
                // natural wrap at depth
                pc_q      <= fetch_addr + 1'b1;
                fetched_q <= 1'b1;
            end
        end
    end

    // zero until the first fetch
    assign instruction_o = fetched_q ? mem.rd_data : '0;

endmodule

//--- rtl/instr_mem.sv
`timescale 1ns/1ps

module instr_mem (
    input  logic         clock,
    imem_port_if.memory  mem
);
    import loader_pkg::*;

    // program storage, filled only by the loader
    logic [WORD_W-1:0] mem_array [IMEM_DEPTH];
    logic [WORD_W-1:0] rd_q;

    // write port
    always_ff @(posedge clock) begin
        if (mem.wr_en) begin
            mem_array[mem.wr_addr] <= mem.wr_data;
        end
    end

    // registered read, holds its word until the next rd_en
    always_ff @(posedge clock) begin
        if (mem.rd_en) begin
            rd_q <= mem_array[mem.rd_addr];
        end
    end

    assign mem.rd_data = rd_q;

endmodule

//--- rtl/instr_loader.sv
`timescale 1ns/1ps

module instr_loader (
    input  logic                           clock,
    input  logic                           rst_i,
    input  logic [loader_pkg::BYTE_W-1:0]  byte_i,
    input  logic                           byte_done_i,
    imem_port_if.loader                    mem,
    output logic [loader_pkg::COUNT_W-1:0] load_count_o
);
    import loader_pkg::*;

    logic [$clog2(BYTES_PER_WORD)-1:0] byte_cnt;
    logic [WORD_W-1:0]                 word_q;
    logic [ADDR_W-1:0]                 addr_q;
    logic                              wr_q;
    logic                              word_full;

    // fourth byte of the group arriving
    assign word_full = byte_done_i && (byte_cnt == BYTES_PER_WORD - 1);

    always_ff @(posedge clock) begin
        if (rst_i) begin
            byte_cnt     <= '0;
            wr_q         <= 1'b0;
            load_count_o <= '0;
        end else begin
            wr_q <= word_full;
            if (byte_done_i) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
            // count moves together with the write
            if (word_full) begin
                load_count_o <= load_count_o + 1'b1;
            end
        end
    end

    // bytes enter at the top, first one ends in 7:0
    always_ff @(posedge clock) begin
        if (byte_done_i) begin
            word_q <= {byte_i, word_q[WORD_W-1:BYTE_W]};
        end
        // address taken before the count moves, wraps at depth
        if (word_full) begin
            addr_q <= load_count_o[ADDR_W-1:0];
        end
    end

    assign mem.wr_en   = wr_q;
    assign mem.wr_addr = addr_q;
    assign mem.wr_data = word_q;

endmodule

//--- rtl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
    input  logic                          clock,
    input  logic                          rst_i,
    input  logic                          tick_i,
    input  logic                          rx_serial_i,
    output logic [loader_pkg::BYTE_W-1:0] rx_data_o,
    output logic                          rx_done_o
);
    import loader_pkg::*;

    rx_state_t                        state;
    logic [$clog2(TICKS_PER_BIT)-1:0] tick_cnt;
    logic [$clog2(BYTE_W)-1:0]        bit_cnt;
    logic [BYTE_W-1:0]                data_q;
    logic                             serial_q;
    logic                             mid_start;
    logic                             mid_bit;

    // half a bit into the start bit
    assign mid_start = tick_i && (tick_cnt == TICKS_PER_BIT / 2 - 1);
    // one full bit later, centre of the next bit
    assign mid_bit   = tick_i && (tick_cnt == TICKS_PER_BIT - 1);

    assign rx_data_o = data_q;

    always_ff @(posedge clock) begin
        if (rst_i) begin
            state     <= RX_IDLE;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
            serial_q  <= 1'b1;
            rx_done_o <= 1'b0;
        end else begin
            // line registered once before use
            serial_q  <= rx_serial_i;
            rx_done_o <= 1'b0;
            if (tick_i) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            case (state)
                RX_IDLE: begin
                    // falling edge on the line
                    if (!serial_q) begin
                        tick_cnt <= '0;
                        state    <= RX_START;
                    end
                end
                RX_START: begin
                    if (mid_start) begin
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        // glitch, not a real start bit
                        state    <= serial_q ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (mid_bit) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BYTE_W - 1) begin
                            state <= RX_STOP;
                        end
                    end
                end
                default: begin
                    // stop bit centre, byte handed on
                    if (mid_bit) begin
                        rx_done_o <= 1'b1;
                        state     <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    // sampled bits enter at the msb, first bit ends at bit 0
    always_ff @(posedge clock) begin
        if (state == RX_DATA && mid_bit) begin
            data_q <= {serial_q, data_q[BYTE_W-1:1]};
        end
    end

endmodule

//--- rtl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
    input  logic                          clock,
    input  logic                          rst_i,
    input  logic                          tick_i,
    input  logic                          tx_start_i,
    input  logic [loader_pkg::BYTE_W-1:0] tx_data_i,
    output logic                          tx_serial_o,
    output logic                          tx_busy_o,
    output logic                          tx_done_o
);
    import loader_pkg::*;

    tx_state_t                        state;
    logic [$clog2(TICKS_PER_BIT)-1:0] tick_cnt;
    logic [$clog2(BYTE_W)-1:0]        bit_cnt;
    logic [BYTE_W-1:0]                shift_q;
    logic                             serial_q;
    logic                             bit_end;

    // last oversampling tick of the current bit
    assign bit_end = tick_i && (tick_cnt == TICKS_PER_BIT - 1);

    // start strobes only count while idle
    assign tx_busy_o   = (state != TX_IDLE);
    assign tx_serial_o = serial_q;

    always_ff @(posedge clock) begin
        if (rst_i) begin
            state     <= TX_IDLE;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
            serial_q  <= 1'b1;
            tx_done_o <= 1'b0;
        end else begin
            tx_done_o <= 1'b0;
            if (tick_i) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            case (state)
                TX_IDLE: begin
                    serial_q <= 1'b1;
                    if (tx_start_i) begin
                        // start bit goes out right away
                        tick_cnt <= '0;
                        serial_q <= 1'b0;
                        state    <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        bit_cnt  <= '0;
                        serial_q <= shift_q[0];
                        state    <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_cnt == BYTE_W - 1) begin
                            serial_q <= 1'b1;
                            state    <= TX_STOP;
                        end else begin
                            // next lsb after the shift below
                            serial_q <= shift_q[1];
                            bit_cnt  <= bit_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    // stop bit done, busy falls with the pulse
                    if (bit_end) begin
                        tx_done_o <= 1'b1;
                        state     <= TX_IDLE;
                    end
                end
            endcase
        end
    end

    // payload shifter, lsb first
    always_ff @(posedge clock) begin
        if (state == TX_IDLE && tx_start_i) begin
            shift_q <= tx_data_i;
        end else if (state == TX_DATA && bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

//--- rtl/baud_tick_gen.sv
`timescale 1ns/1ps

module baud_tick_gen (
    input  logic clock,
    input  logic rst_i,
    output logic tick_o
);
    import loader_pkg::*;

    // free running divider, one tick per wrap
    logic [$clog2(CLKS_PER_TICK)-1:0] clk_cnt;

    always_ff @(posedge clock) begin
        if (rst_i) begin
            clk_cnt <= '0;
            tick_o  <= 1'b0;
        end else begin
            // tick is registered, lands one clock after the wrap
            if (clk_cnt == CLKS_PER_TICK - 1) begin
                clk_cnt <= '0;
                tick_o  <= 1'b1;
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
                tick_o  <= 1'b0;
            end
        end
    end

endmodule

//--- rtl/imem_port_if.sv
`timescale 1ns/1ps

interface imem_port_if;
    import loader_pkg::*;

    // write side, owned by the loader
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    logic [WORD_W-1:0] wr_data;

    // read side, address from fetch, data from memory
    logic              rd_en;
    logic [ADDR_W-1:0] rd_addr;
    logic [WORD_W-1:0] rd_data;

    modport loader (output wr_en, output wr_addr, output wr_data);
    modport fetch  (output rd_en, output rd_addr, input rd_data);
    modport memory (input wr_en, input wr_addr, input wr_data,
                    input rd_en, input rd_addr, output rd_data);

endinterface

//--- rtl/loader_pkg.sv
package loader_pkg;

    // byte and word geometry
    localparam int BYTE_W         = 8;
    localparam int WORD_W         = 32;
    localparam int BYTES_PER_WORD = 4;

    // instruction memory and pc
    localparam int IMEM_DEPTH = 128;
    localparam int ADDR_W     = 7;

    // register file index width
    localparam int REG_ADDR_W = 5;

    // width of the loaded word counter
    localparam int COUNT_W = 16;

    // baud timing, 16x oversampling
    localparam int CLKS_PER_TICK = 163;
    localparam int TICKS_PER_BIT = 16;

    // transmitter FSM
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    // receiver FSM
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

endpackage
